//--- source/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

`define CSR_DWORD_W 64
`define CSR_ADDR_W  12
`define CSR_ECODE_W 16

// Machine trap setup and handling
`define CSR_ADDR_MSTATUS       12'h300
`define CSR_ADDR_MISA          12'h301
`define CSR_ADDR_MIE           12'h304
`define CSR_ADDR_MTVEC         12'h305
`define CSR_ADDR_MCOUNTEREN    12'h306
`define CSR_ADDR_MCOUNTINHIBIT 12'h320
`define CSR_ADDR_MSCRATCH      12'h340
`define CSR_ADDR_MEPC          12'h341
`define CSR_ADDR_MCAUSE        12'h342
`define CSR_ADDR_MTVAL         12'h343
`define CSR_ADDR_MIP           12'h344

// Counters and their user shadows
`define CSR_ADDR_MCYCLE        12'hb00
`define CSR_ADDR_MINSTRET      12'hb02
`define CSR_ADDR_CYCLE         12'hc00
`define CSR_ADDR_INSTRET       12'hc02

`define CSR_ADDR_MVENDORID     12'hf11
`define CSR_ADDR_MARCHID       12'hf12
`define CSR_ADDR_MIMPID        12'hf13
`define CSR_ADDR_MHARTID       12'hf14

// MXL = 2, extensions A, I, S, U
`define CSR_MISA_VALUE    64'h8000_0000_0014_0101
`define CSR_MARCHID_VALUE 64'd13
`define CSR_MIMPID_VALUE  64'd1

`endif

//--- source/csr_pkg.sv
package csr_pkg;

   typedef enum logic [1:0]
   {
      e_priv_u = 2'd0,
      e_priv_m = 2'd3
   } priv_e;

   typedef enum logic [3:0]
   {
      e_csrrw    = 4'd0,
      e_csrrs    = 4'd1,
      e_csrrc    = 4'd2,
      e_csrrwi   = 4'd3,
      e_csrrsi   = 4'd4,
      e_csrrci   = 4'd5,
      e_mret     = 4'd6,
      e_wfi      = 4'd7,
      e_take_irq = 4'd8
   } csr_op_e;

   // One value per implemented CSR
   typedef enum logic [4:0]
   {
      e_sel_none,
      e_sel_mstatus,
      e_sel_misa,
      e_sel_mie,
      e_sel_mtvec,
      e_sel_mcounteren,
      e_sel_mcountinhibit,
      e_sel_mscratch,
      e_sel_mepc,
      e_sel_mcause,
      e_sel_mtval,
      e_sel_mip,
      e_sel_mcycle,
      e_sel_minstret,
      e_sel_cycle,
      e_sel_instret,
      e_sel_mvendorid,
      e_sel_marchid,
      e_sel_mimpid,
      e_sel_mhartid
   } csr_sel_e;

endpackage

//--- source/csr_decode.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_decode
   import csr_pkg::*;
(
   input  csr_op_e                cmd_op_i,
   input  logic [`CSR_ADDR_W-1:0] cmd_addr_i,
   input  priv_e                  priv_i,
   input  logic                   mcounteren_cy_i,
   input  logic                   mcounteren_ir_i,
   input  logic                   mstatus_tw_i,
   output csr_sel_e               sel_o,
   output logic                   is_access_o,
   output logic                   illegal_o
);

   logic user_mode;

   assign user_mode   = (priv_i == e_priv_u);
   assign is_access_o = cmd_op_i inside {e_csrrw, e_csrrs, e_csrrc,
                                         e_csrrwi, e_csrrsi, e_csrrci};

   always_comb
   begin
      case (cmd_addr_i)
         `CSR_ADDR_MSTATUS:       sel_o = e_sel_mstatus;
         `CSR_ADDR_MISA:          sel_o = e_sel_misa;
         `CSR_ADDR_MIE:           sel_o = e_sel_mie;
         `CSR_ADDR_MTVEC:         sel_o = e_sel_mtvec;
         `CSR_ADDR_MCOUNTEREN:    sel_o = e_sel_mcounteren;
         `CSR_ADDR_MCOUNTINHIBIT: sel_o = e_sel_mcountinhibit;
         `CSR_ADDR_MSCRATCH:      sel_o = e_sel_mscratch;
         `CSR_ADDR_MEPC:          sel_o = e_sel_mepc;
         `CSR_ADDR_MCAUSE:        sel_o = e_sel_mcause;
         `CSR_ADDR_MTVAL:         sel_o = e_sel_mtval;
         `CSR_ADDR_MIP:           sel_o = e_sel_mip;
         `CSR_ADDR_MCYCLE:        sel_o = e_sel_mcycle;
         `CSR_ADDR_MINSTRET:      sel_o = e_sel_minstret;
         `CSR_ADDR_CYCLE:         sel_o = e_sel_cycle;
         `CSR_ADDR_INSTRET:       sel_o = e_sel_instret;
         `CSR_ADDR_MVENDORID:     sel_o = e_sel_mvendorid;
         `CSR_ADDR_MARCHID:       sel_o = e_sel_marchid;
         `CSR_ADDR_MIMPID:        sel_o = e_sel_mimpid;
         `CSR_ADDR_MHARTID:       sel_o = e_sel_mhartid;
         default:                 sel_o = e_sel_none;
      endcase
   end

   always_comb
   begin
      illegal_o = 1'b0;
      if (is_access_o)
      begin
         if (sel_o == e_sel_none)
            illegal_o = 1'b1;
         // Bits 9:8 give the lowest privilege allowed
         else if (priv_i < cmd_addr_i[9:8])
            illegal_o = 1'b1;
         else if (user_mode && (sel_o == e_sel_cycle) && !mcounteren_cy_i)
            illegal_o = 1'b1;
         else if (user_mode && (sel_o == e_sel_instret) && !mcounteren_ir_i)
            illegal_o = 1'b1;
      end
      else if (cmd_op_i == e_mret)
         illegal_o = user_mode;
      else if (cmd_op_i == e_wfi)
         illegal_o = mstatus_tw_i;
   end

endmodule

//--- source/csr_irq_trap.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_irq_trap
   import csr_pkg::*;
(
   input  priv_e                   priv_i,
   input  logic                    mstatus_mie_i,
   input  logic [`CSR_ECODE_W-1:0] mie_i,
   input  logic [`CSR_ECODE_W-1:0] mip_i,
   input  logic                    exception_v_i,
   input  logic [`CSR_ECODE_W-1:0] exception_ecode_i,
   output logic                    take_exc_o,
   output logic                    irq_pending_o,
   output logic [3:0]              cause_code_o,
   output logic                    cause_is_instr_o
);

   logic                    global_ie;
   logic [`CSR_ECODE_W-1:0] irq_vec;
   logic [3:0]              exc_code;
   logic [3:0]              irq_code;

   // Index of the lowest set bit
   function automatic logic [3:0] lowest_index(input logic [`CSR_ECODE_W-1:0] vec);
      lowest_index = 4'd0;
      for (int i = `CSR_ECODE_W-1; i >= 0; i--)
      begin
         if (vec[i])
            lowest_index = 4'(i);
      end
   endfunction

   // Lower privilege always sees M interrupts enabled
   assign global_ie = (mstatus_mie_i && (priv_i == e_priv_m)) || (priv_i == e_priv_u);

   assign irq_vec       = mie_i & mip_i & {`CSR_ECODE_W{global_ie}};
   assign irq_pending_o = |irq_vec;
   assign irq_code      = lowest_index(irq_vec);

   assign take_exc_o = exception_v_i && (|exception_ecode_i);
   assign exc_code   = lowest_index(exception_ecode_i);

   assign cause_code_o     = take_exc_o ? exc_code : irq_code;
   // Cause 2 is the illegal instruction
   assign cause_is_instr_o = take_exc_o && (exc_code == 4'd2);

endmodule

//--- source/csr_regfile.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_regfile
   import csr_pkg::*;
#(
   parameter int hart_id_p = 0
)
(
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    cmd_v_i,
   input  csr_op_e                 cmd_op_i,
   input  logic [`CSR_DWORD_W-1:0] cmd_data_i,
   input  csr_sel_e                sel_i,
   input  logic                    is_access_i,
   input  logic                    illegal_i,
   input  logic                    take_exc_i,
   input  logic                    irq_pending_i,
   input  logic [3:0]              cause_code_i,
   input  logic                    cause_is_instr_i,
   input  logic [`CSR_DWORD_W-1:0] exception_pc_i,
   input  logic [`CSR_DWORD_W-1:0] exception_vaddr_i,
   input  logic [31:0]             exception_instr_i,
   input  logic                    instret_i,
   input  logic                    timer_irq_i,
   input  logic                    software_irq_i,
   input  logic                    external_irq_i,
   output logic [`CSR_DWORD_W-1:0] rdata_o,
   output priv_e                   priv_o,
   output logic                    mstatus_mie_o,
   output logic [`CSR_ECODE_W-1:0] mie_o,
   output logic [`CSR_ECODE_W-1:0] mip_o,
   output logic                    mcounteren_cy_o,
   output logic                    mcounteren_ir_o,
   output logic                    mstatus_tw_o,
   output logic                    exc_o,
   output logic                    irq_o,
   output logic                    eret_o,
   output logic [`CSR_DWORD_W-1:0] npc_o
);

   priv_e                   priv_r;
   logic                    mstatus_mie_r;
   logic                    mstatus_mpie_r;
   priv_e                   mstatus_mpp_r;
   logic                    mstatus_tw_r;
   logic [`CSR_ECODE_W-1:0] mie_r;
   logic [`CSR_ECODE_W-1:0] mip_r;
   logic [`CSR_DWORD_W-1:0] mtvec_r;
   logic                    mcounteren_cy_r;
   logic                    mcounteren_ir_r;
   logic                    inhibit_cy_r;
   logic                    inhibit_ir_r;
   logic [`CSR_DWORD_W-1:0] mscratch_r;
   logic [`CSR_DWORD_W-1:0] mepc_r;
   logic [`CSR_DWORD_W-1:0] mcause_r;
   logic [`CSR_DWORD_W-1:0] mtval_r;
   logic [`CSR_DWORD_W-1:0] mcycle_r;
   logic [`CSR_DWORD_W-1:0] minstret_r;

   logic [`CSR_DWORD_W-1:0] mstatus_rd;
   logic [`CSR_DWORD_W-1:0] operand;
   logic [`CSR_DWORD_W-1:0] wdata;
   logic                    is_imm;
   logic                    is_write_op;
   logic                    csr_we;
   logic                    trap;
   logic                    mret;

   // MIE bit 3, MPIE bit 7, MPP bits 12:11, TW bit 21
   assign mstatus_rd = `CSR_DWORD_W'({mstatus_tw_r, 8'b0, mstatus_mpp_r, 3'b0,
                                      mstatus_mpie_r, 3'b0, mstatus_mie_r, 3'b0});

   always_comb
   begin
      case (sel_i)
         e_sel_mstatus:       rdata_o = mstatus_rd;
         e_sel_misa:          rdata_o = `CSR_MISA_VALUE;
         e_sel_mie:           rdata_o = `CSR_DWORD_W'(mie_r);
         e_sel_mtvec:         rdata_o = mtvec_r;
         e_sel_mcounteren:    rdata_o = `CSR_DWORD_W'({mcounteren_ir_r, 1'b0, mcounteren_cy_r});
         e_sel_mcountinhibit: rdata_o = `CSR_DWORD_W'({inhibit_ir_r, 1'b0, inhibit_cy_r});
         e_sel_mscratch:      rdata_o = mscratch_r;
         e_sel_mepc:          rdata_o = mepc_r;
         e_sel_mcause:        rdata_o = mcause_r;
         e_sel_mtval:         rdata_o = mtval_r;
         e_sel_mip:           rdata_o = `CSR_DWORD_W'(mip_r);
         e_sel_mcycle:        rdata_o = mcycle_r;
         e_sel_cycle:         rdata_o = mcycle_r;
         e_sel_minstret:      rdata_o = minstret_r;
         e_sel_instret:       rdata_o = minstret_r;
         e_sel_marchid:       rdata_o = `CSR_MARCHID_VALUE;
         e_sel_mimpid:        rdata_o = `CSR_MIMPID_VALUE;
         e_sel_mhartid:       rdata_o = `CSR_DWORD_W'(hart_id_p);
         // mvendorid reads zero
         default:             rdata_o = '0;
      endcase
   end

   assign is_imm  = cmd_op_i inside {e_csrrwi, e_csrrsi, e_csrrci};
   assign operand = is_imm ? `CSR_DWORD_W'(cmd_data_i[4:0]) : cmd_data_i;

   always_comb
   begin
      case (cmd_op_i)
         e_csrrw, e_csrrwi: wdata = operand;
         e_csrrs, e_csrrsi: wdata = rdata_o | operand;
         e_csrrc, e_csrrci: wdata = rdata_o & ~operand;
         default:           wdata = rdata_o;
      endcase
   end

   // Set and clear with a zero operand only read, so counters keep running
   assign is_write_op = (cmd_op_i inside {e_csrrw, e_csrrwi}) || (operand != '0);
   assign csr_we      = cmd_v_i && is_access_i && !illegal_i && !take_exc_i && is_write_op;

   assign trap = take_exc_i || (cmd_v_i && (cmd_op_i == e_take_irq) && irq_pending_i);
   assign mret = cmd_v_i && (cmd_op_i == e_mret) && !illegal_i && !take_exc_i;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         priv_r          <= e_priv_m;
         mstatus_mie_r   <= 1'b0;
         mstatus_mpie_r  <= 1'b0;
         mstatus_mpp_r   <= e_priv_u;
         mstatus_tw_r    <= 1'b0;
         mie_r           <= '0;
         mip_r           <= '0;
         mtvec_r         <= '0;
         mcounteren_cy_r <= 1'b0;
         mcounteren_ir_r <= 1'b0;
         inhibit_cy_r    <= 1'b0;
         inhibit_ir_r    <= 1'b0;
         mscratch_r      <= '0;
         mepc_r          <= '0;
         mcause_r        <= '0;
         mtval_r         <= '0;
         mcycle_r        <= '0;
         minstret_r      <= '0;
      end
      else
      begin
         mip_r <= {4'b0, external_irq_i, 3'b0, timer_irq_i, 3'b0, software_irq_i, 3'b0};

         if (!inhibit_cy_r)
            mcycle_r <= mcycle_r + 1'b1;
         if (!inhibit_ir_r && instret_i)
            minstret_r <= minstret_r + 1'b1;

         // Software writes override the increments above
         if (csr_we)
         begin
            case (sel_i)
               e_sel_mstatus:
               begin
                  mstatus_mie_r  <= wdata[3];
                  mstatus_mpie_r <= wdata[7];
                  mstatus_mpp_r  <= (wdata[12:11] == 2'b11) ? e_priv_m : e_priv_u;
                  mstatus_tw_r   <= wdata[21];
               end
               e_sel_mie:
                  mie_r <= {4'b0, wdata[11], 3'b0, wdata[7], 3'b0, wdata[3], 3'b0};
               e_sel_mtvec:
                  mtvec_r <= wdata;
               e_sel_mcounteren:
               begin
                  mcounteren_cy_r <= wdata[0];
                  mcounteren_ir_r <= wdata[2];
               end
               e_sel_mcountinhibit:
               begin
                  inhibit_cy_r <= wdata[0];
                  inhibit_ir_r <= wdata[2];
               end
               e_sel_mscratch: mscratch_r <= wdata;
               e_sel_mepc:     mepc_r     <= wdata;
               e_sel_mcause:   mcause_r   <= wdata;
               e_sel_mtval:    mtval_r    <= wdata;
               e_sel_mcycle:   mcycle_r   <= wdata;
               e_sel_minstret: minstret_r <= wdata;
               default: ;
            endcase
         end

         if (trap)
         begin
            priv_r         <= e_priv_m;
            mstatus_mpp_r  <= priv_r;
            mstatus_mpie_r <= mstatus_mie_r;
            mstatus_mie_r  <= 1'b0;
            mepc_r         <= exception_pc_i;
            mcause_r       <= {irq_o, {(`CSR_DWORD_W-5){1'b0}}, cause_code_i};
            mtval_r        <= irq_o ? '0
                              : (cause_is_instr_i ? `CSR_DWORD_W'(exception_instr_i)
                                                  : exception_vaddr_i);
         end
         else if (mret)
         begin
            priv_r         <= mstatus_mpp_r;
            mstatus_mie_r  <= mstatus_mpie_r;
            mstatus_mpie_r <= 1'b1;
            mstatus_mpp_r  <= e_priv_u;
         end
      end
   end

   assign priv_o          = priv_r;
   assign mstatus_mie_o   = mstatus_mie_r;
   assign mstatus_tw_o    = mstatus_tw_r;
   assign mie_o           = mie_r;
   assign mip_o           = mip_r;
   assign mcounteren_cy_o = mcounteren_cy_r;
   assign mcounteren_ir_o = mcounteren_ir_r;

   assign exc_o  = take_exc_i;
   assign irq_o  = trap && !take_exc_i;
   assign eret_o = mret;
   assign npc_o  = mret ? mepc_r : mtvec_r;

endmodule

//--- source/csr_unit.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_unit
   import csr_pkg::*;
#(
   parameter int hart_id_p = 0
)
(
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  logic                    cmd_v_i,
   input  csr_op_e                 cmd_op_i,
   input  logic [`CSR_ADDR_W-1:0]  cmd_addr_i,
   input  logic [`CSR_DWORD_W-1:0] cmd_data_i,
   input  logic                    exception_v_i,
   input  logic [`CSR_ECODE_W-1:0] exception_ecode_i,
   input  logic [`CSR_DWORD_W-1:0] exception_pc_i,
   input  logic [`CSR_DWORD_W-1:0] exception_vaddr_i,
   input  logic [31:0]             exception_instr_i,
   input  logic                    timer_irq_i,
   input  logic                    software_irq_i,
   input  logic                    external_irq_i,
   input  logic                    instret_i,
   output logic [`CSR_DWORD_W-1:0] data_o,
   output logic                    v_o,
   output logic                    illegal_instr_o,
   output logic                    trap_exception_o,
   output logic                    trap_interrupt_o,
   output logic                    trap_eret_o,
   output logic [`CSR_DWORD_W-1:0] trap_npc_o,
   output priv_e                   priv_mode_o,
   output logic                    accept_irq_o
);

   csr_sel_e                sel;
   logic                    is_access;
   logic                    illegal;
   priv_e                   priv;
   logic                    mstatus_mie;
   logic                    mstatus_tw;
   logic [`CSR_ECODE_W-1:0] mie;
   logic [`CSR_ECODE_W-1:0] mip;
   logic                    mcounteren_cy;
   logic                    mcounteren_ir;
   logic                    take_exc;
   logic                    irq_pending;
   logic [3:0]              cause_code;
   logic                    cause_is_instr;
   logic [`CSR_DWORD_W-1:0] rdata;
   logic                    exc;
   logic                    irq;
   logic                    eret;
   logic [`CSR_DWORD_W-1:0] npc;

   csr_decode u_decode
   (
      .cmd_op_i        (cmd_op_i),
      .cmd_addr_i      (cmd_addr_i),
      .priv_i          (priv),
      .mcounteren_cy_i (mcounteren_cy),
      .mcounteren_ir_i (mcounteren_ir),
      .mstatus_tw_i    (mstatus_tw),
      .sel_o           (sel),
      .is_access_o     (is_access),
      .illegal_o       (illegal)
   );

   csr_irq_trap u_irq_trap
   (
      .priv_i            (priv),
      .mstatus_mie_i     (mstatus_mie),
      .mie_i             (mie),
      .mip_i             (mip),
      .exception_v_i     (exception_v_i),
      .exception_ecode_i (exception_ecode_i),
      .take_exc_o        (take_exc),
      .irq_pending_o     (irq_pending),
      .cause_code_o      (cause_code),
      .cause_is_instr_o  (cause_is_instr)
   );

   csr_regfile #(.hart_id_p(hart_id_p)) u_regfile
   (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .cmd_v_i           (cmd_v_i),
      .cmd_op_i          (cmd_op_i),
      .cmd_data_i        (cmd_data_i),
      .sel_i             (sel),
      .is_access_i       (is_access),
      .illegal_i         (illegal),
      .take_exc_i        (take_exc),
      .irq_pending_i     (irq_pending),
      .cause_code_i      (cause_code),
      .cause_is_instr_i  (cause_is_instr),
      .exception_pc_i    (exception_pc_i),
      .exception_vaddr_i (exception_vaddr_i),
      .exception_instr_i (exception_instr_i),
      .instret_i         (instret_i),
      .timer_irq_i       (timer_irq_i),
      .software_irq_i    (software_irq_i),
      .external_irq_i    (external_irq_i),
      .rdata_o           (rdata),
      .priv_o            (priv),
      .mstatus_mie_o     (mstatus_mie),
      .mie_o             (mie),
      .mip_o             (mip),
      .mcounteren_cy_o   (mcounteren_cy),
      .mcounteren_ir_o   (mcounteren_ir),
      .mstatus_tw_o      (mstatus_tw),
      .exc_o             (exc),
      .irq_o             (irq),
      .eret_o            (eret),
      .npc_o             (npc)
   );

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         v_o              <= 1'b0;
         illegal_instr_o  <= 1'b0;
         trap_exception_o <= 1'b0;
         trap_interrupt_o <= 1'b0;
         trap_eret_o      <= 1'b0;
      end
      else
      begin
         v_o              <= cmd_v_i;
         illegal_instr_o  <= cmd_v_i && illegal;
         trap_exception_o <= exc;
         trap_interrupt_o <= irq;
         trap_eret_o      <= eret;
      end
   end

   // Result payload
   always_ff @(posedge clk_i)
   begin
      data_o     <= rdata;
      trap_npc_o <= npc;
   end

   assign priv_mode_o  = priv;
   assign accept_irq_o = irq_pending && !exc && !irq;

endmodule

//--- testbench/csr_unit_tb.sv
`timescale 1ns/1ns
`include "csr_cfg.svh"

module csr_unit_tb
   import csr_pkg::*;
();

   // Commands issued, each within 4 cycles, plus the fixed waits
   localparam int N_ACCESS = 89;
   localparam int WAIT_CYCLES = 40;
   localparam int TIMEOUT = 8 + N_ACCESS * 4 + WAIT_CYCLES + 200;

   logic clk_i, rst_i, cmd_v_i, exception_v_i;
   csr_op_e cmd_op_i;
   logic [`CSR_ADDR_W-1:0] cmd_addr_i;
   logic [63:0] cmd_data_i, exception_pc_i, exception_vaddr_i, data_o, trap_npc_o;
   logic [`CSR_ECODE_W-1:0] exception_ecode_i;
   logic [31:0] exception_instr_i;
   logic timer_irq_i, software_irq_i, external_irq_i, instret_i;
   logic v_o, illegal_instr_o, trap_exception_o, trap_interrupt_o, trap_eret_o, accept_irq_o;
   priv_e priv_mode_o;

   // Expected result of the command in flight
   logic chk_q, exp_v, exp_ill, exp_exc, exp_irq, exp_eret, chk_data, chk_npc;
   logic [63:0] exp_data, exp_npc;
   int cyc, issue_cyc, errors, test_start, tests, failed_tests;
   logic [15:0] lfsr;

   // Reference state
   logic [63:0] m_scratch, m_tvec, m_epc, m_cause, m_tval;
   logic m_mie, m_mpie;
   logic [1:0] m_mpp, m_priv;

   csr_unit #(.hart_id_p(5)) DUT (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   always @(posedge clk_i)
   begin
      cyc <= cyc + 1;
      if (cyc == TIMEOUT)
      begin
         $display("Run did not finish within %0d cycles", TIMEOUT);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   task automatic report_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
   endtask

   a_v: assert property (@(posedge clk_i) disable iff (rst_i) chk_q |=> (v_o == exp_v))
      else report_value("v_o", 64'($sampled(v_o)), 64'($sampled(exp_v)));
   a_ill: assert property (@(posedge clk_i) disable iff (rst_i)
                           chk_q |=> (illegal_instr_o == exp_ill))
      else report_value("illegal_instr_o", 64'($sampled(illegal_instr_o)),
                        64'($sampled(exp_ill)));
   a_exc: assert property (@(posedge clk_i) disable iff (rst_i)
                           chk_q |=> (trap_exception_o == exp_exc))
      else report_value("trap_exception_o", 64'($sampled(trap_exception_o)),
                        64'($sampled(exp_exc)));
   a_irq: assert property (@(posedge clk_i) disable iff (rst_i)
                           chk_q |=> (trap_interrupt_o == exp_irq))
      else report_value("trap_interrupt_o", 64'($sampled(trap_interrupt_o)),
                        64'($sampled(exp_irq)));
   a_eret: assert property (@(posedge clk_i) disable iff (rst_i)
                            chk_q |=> (trap_eret_o == exp_eret))
      else report_value("trap_eret_o", 64'($sampled(trap_eret_o)), 64'($sampled(exp_eret)));
   a_data: assert property (@(posedge clk_i) disable iff (rst_i)
                            (chk_q && chk_data) |=> (data_o == exp_data))
      else report_value("data_o", $sampled(data_o), $sampled(exp_data));
   a_npc: assert property (@(posedge clk_i) disable iff (rst_i)
                           (chk_q && chk_npc) |=> (trap_npc_o == exp_npc))
      else report_value("trap_npc_o", $sampled(trap_npc_o), $sampled(exp_npc));

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         r = {r[62:0], lfsr[15]};
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
      return r;
   endfunction

   function automatic logic [63:0] apply_op(input csr_op_e op, input logic [63:0] old,
                                            input logic [63:0] data);
      logic [63:0] opnd;
      opnd = (op inside {e_csrrwi, e_csrrsi, e_csrrci}) ? {59'b0, data[4:0]} : data;
      case (op)
         e_csrrs, e_csrrsi: return old | opnd;
         e_csrrc, e_csrrci: return old & ~opnd;
         default:           return opnd;
      endcase
   endfunction

   function automatic logic [63:0] mstatus_val();
      return (64'(m_mpp) << 11) | (64'(m_mpie) << 7) | (64'(m_mie) << 3);
   endfunction

   task automatic set_mstatus(input logic [63:0] w);
      m_mie = w[3];
      m_mpie = w[7];
      m_mpp = (w[12:11] == 2'b11) ? 2'd3 : 2'd0;
   endtask

   task automatic expect_flags(input logic ill, exc, irq, eret, n_chk, input logic [63:0] n);
      exp_ill = ill;
      exp_exc = exc;
      exp_irq = irq;
      exp_eret = eret;
      chk_npc = n_chk;
      exp_npc = n;
   endtask

   task automatic issue(input logic cv, input csr_op_e op, input logic [11:0] addr,
                        input logic [63:0] data, input logic ev, output logic [63:0] rd);
      exp_v = cv;
      @(posedge clk_i);
      cmd_v_i <= cv;
      cmd_op_i <= op;
      cmd_addr_i <= addr;
      cmd_data_i <= data;
      exception_v_i <= ev;
      chk_q <= 1'b1;
      issue_cyc = cyc;
      @(posedge clk_i);
      cmd_v_i <= 1'b0;
      exception_v_i <= 1'b0;
      chk_q <= 1'b0;
      @(negedge clk_i);
      rd = data_o;
      @(posedge clk_i);
   endtask

   task automatic access(input csr_op_e op, input logic [11:0] addr, input logic [63:0] data,
                         input logic chk, input logic [63:0] expd, input logic ill,
                         output logic [63:0] rd);
      expect_flags(ill, 1'b0, 1'b0, 1'b0, 1'b0, '0);
      chk_data = chk;
      exp_data = expd;
      issue(1'b1, op, addr, data, 1'b0, rd);
   endtask

   task automatic enter_trap(input logic is_irq, input logic [3:0] code, input logic [63:0] pc,
                             input logic [63:0] tval);
      m_epc = pc;
      m_cause = {is_irq, 59'b0, code};
      m_tval = tval;
      m_mpp = m_priv;
      m_mpie = m_mie;
      m_mie = 1'b0;
      m_priv = 2'd3;
   endtask

   task automatic raise_exc(input logic [15:0] ecode, input logic [3:0] code);
      logic [63:0] pc, va, rd;
      logic [31:0] instr;
      pc = rand_bits(64);
      va = rand_bits(64);
      instr = 32'(rand_bits(32));
      @(posedge clk_i);
      exception_ecode_i <= ecode;
      exception_pc_i <= pc;
      exception_vaddr_i <= va;
      exception_instr_i <= instr;
      expect_flags(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, m_tvec);
      chk_data = 1'b0;
      issue(1'b0, e_csrrs, '0, '0, 1'b1, rd);
      enter_trap(1'b0, code, pc, (code == 4'd2) ? {32'b0, instr} : va);
   endtask

   task automatic do_mret(input logic ill);
      logic [63:0] rd;
      expect_flags(ill, 1'b0, 1'b0, !ill, !ill, m_epc);
      chk_data = 1'b0;
      issue(1'b1, e_mret, '0, '0, 1'b0, rd);
      if (!ill)
      begin
         m_priv = m_mpp;
         m_mie = m_mpie;
         m_mpie = 1'b1;
         m_mpp = 2'd0;
      end
   endtask

   task automatic check_state(input logic exp_accept);
      @(negedge clk_i);
      assert (priv_mode_o == priv_e'(m_priv))
         else report_value("priv_mode_o", 64'(priv_mode_o), 64'(m_priv));
      assert (accept_irq_o == exp_accept)
         else report_value("accept_irq_o", 64'(accept_irq_o), 64'(exp_accept));
   endtask

   task automatic finish_test(input string name);
      @(negedge clk_i);
      tests++;
      if (errors == test_start)
         $display("test %s: pass", name);
      else
      begin
         $display("test %s: fail, %0d errors", name, errors - test_start);
         failed_tests++;
      end
      test_start = errors;
   endtask

   initial
   begin
      logic [63:0] d, a, b, rd;
      csr_op_e op;
      rst_i = 1'b1;
      {cmd_v_i, exception_v_i, chk_q, timer_irq_i, software_irq_i, external_irq_i} = '0;
      instret_i = 1'b0;
      cmd_op_i = e_csrrw;
      {cmd_addr_i, cmd_data_i, exception_ecode_i, exception_pc_i} = '0;
      {exception_vaddr_i, exception_instr_i} = '0;
      {cyc, errors, test_start, tests, failed_tests, issue_cyc} = '0;
      lfsr = 16'd38283;
      {m_scratch, m_tvec, m_epc, m_cause, m_tval, m_mie, m_mpie, m_mpp} = '0;
      m_priv = 2'd3;
      repeat (8) @(posedge clk_i);
      rst_i <= 1'b0;

      check_state(1'b0);
      for (int i = 0; i < 4; i++)
      begin
         for (int k = 0; k < 6; k++)
         begin
            op = csr_op_e'(k);
            d = rand_bits(64);
            access(op, `CSR_ADDR_MSCRATCH, d, 1'b1, m_scratch, 1'b0, rd);
            m_scratch = apply_op(op, m_scratch, d);
            access(e_csrrs, `CSR_ADDR_MSCRATCH, '0, 1'b1, m_scratch, 1'b0, rd);
         end
      end
      access(e_csrrs, `CSR_ADDR_MISA, '0, 1'b1, 64'h8000_0000_0014_0101, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MARCHID, '0, 1'b1, 64'd13, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MIMPID, '0, 1'b1, 64'd1, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MHARTID, '0, 1'b1, 64'd5, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MVENDORID, '0, 1'b1, 64'd0, 1'b0, rd);
      finish_test("access");

      access(e_csrrw, 12'h7c0, rand_bits(64), 1'b0, '0, 1'b1, rd);
      access(e_csrrs, `CSR_ADDR_MSCRATCH, '0, 1'b1, m_scratch, 1'b0, rd);
      access(e_csrrw, `CSR_ADDR_MSTATUS, '0, 1'b1, mstatus_val(), 1'b0, rd);
      set_mstatus('0);
      do_mret(1'b0);
      check_state(1'b0);
      access(e_csrrw, `CSR_ADDR_MSCRATCH, rand_bits(64), 1'b0, '0, 1'b1, rd);
      access(e_csrrs, `CSR_ADDR_CYCLE, '0, 1'b0, '0, 1'b1, rd);
      raise_exc(16'h0008, 4'd3);
      access(e_csrrs, `CSR_ADDR_MSCRATCH, '0, 1'b1, m_scratch, 1'b0, rd);
      access(e_csrrw, `CSR_ADDR_MCOUNTEREN, 64'd1, 1'b1, '0, 1'b0, rd);
      do_mret(1'b0);
      access(e_csrrs, `CSR_ADDR_CYCLE, '0, 1'b0, '0, 1'b0, rd);
      raise_exc(16'h0008, 4'd3);
      check_state(1'b0);
      finish_test("illegal");

      d = rand_bits(64) & ~64'h3;
      access(e_csrrw, `CSR_ADDR_MTVEC, d, 1'b1, m_tvec, 1'b0, rd);
      m_tvec = d;
      raise_exc(16'h0024, 4'd2);
      access(e_csrrs, `CSR_ADDR_MCAUSE, '0, 1'b1, m_cause, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MTVAL, '0, 1'b1, m_tval, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MEPC, '0, 1'b1, m_epc, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MSTATUS, '0, 1'b1, mstatus_val(), 1'b0, rd);
      check_state(1'b0);
      finish_test("exception");

      access(e_csrrw, `CSR_ADDR_MSTATUS, 64'h80, 1'b1, mstatus_val(), 1'b0, rd);
      set_mstatus(64'h80);
      do_mret(1'b0);
      check_state(1'b0);
      do_mret(1'b1);
      raise_exc(16'h0010, 4'd4);
      // MPIE now holds the MIE that MRET restored
      access(e_csrrs, `CSR_ADDR_MSTATUS, '0, 1'b1, mstatus_val(), 1'b0, rd);
      check_state(1'b0);
      finish_test("mret");

      access(e_csrrw, `CSR_ADDR_MIE, 64'h880, 1'b1, '0, 1'b0, rd);
      access(e_csrrw, `CSR_ADDR_MSTATUS, 64'h8, 1'b1, mstatus_val(), 1'b0, rd);
      set_mstatus(64'h8);
      @(posedge clk_i);
      timer_irq_i <= 1'b1;
      external_irq_i <= 1'b1;
      d = rand_bits(64);
      exception_pc_i <= d;
      repeat (2) @(posedge clk_i);
      check_state(1'b1);
      expect_flags(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, m_tvec);
      chk_data = 1'b0;
      issue(1'b1, e_take_irq, '0, '0, 1'b0, rd);
      enter_trap(1'b1, 4'd7, d, '0);
      check_state(1'b0);
      access(e_csrrs, `CSR_ADDR_MCAUSE, '0, 1'b1, 64'h8000_0000_0000_0007, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MEPC, '0, 1'b1, m_epc, 1'b0, rd);
      @(posedge clk_i);
      timer_irq_i <= 1'b0;
      external_irq_i <= 1'b0;
      finish_test("interrupt");

      access(e_csrrs, `CSR_ADDR_MCYCLE, '0, 1'b0, '0, 1'b0, a);
      d = 64'(issue_cyc);
      repeat (10) @(posedge clk_i);
      access(e_csrrs, `CSR_ADDR_MCYCLE, '0, 1'b0, '0, 1'b0, b);
      assert (b == a + (64'(issue_cyc) - d))
         else report_value("data_o", b, a + (64'(issue_cyc) - d));
      access(e_csrrw, `CSR_ADDR_MCOUNTINHIBIT, 64'd5, 1'b1, '0, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MCYCLE, '0, 1'b0, '0, 1'b0, a);
      repeat (10) @(posedge clk_i);
      access(e_csrrs, `CSR_ADDR_MCYCLE, '0, 1'b1, a, 1'b0, b);
      access(e_csrrw, `CSR_ADDR_MCOUNTINHIBIT, '0, 1'b1, 64'd5, 1'b0, rd);
      access(e_csrrs, `CSR_ADDR_MINSTRET, '0, 1'b0, '0, 1'b0, a);
      @(posedge clk_i);
      instret_i <= 1'b1;
      repeat (7) @(posedge clk_i);
      instret_i <= 1'b0;
      access(e_csrrs, `CSR_ADDR_MINSTRET, '0, 1'b1, a + 64'd7, 1'b0, b);
      finish_test("counters");

      $display("tests run %0d, tests failed %0d, checks failed %0d",
               tests, failed_tests, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- csr_unit.f
+incdir+source
source/csr_pkg.sv
source/csr_decode.sv
source/csr_irq_trap.sv
source/csr_regfile.sv
source/csr_unit.sv
testbench/csr_unit_tb.sv

//--- Makefile
TOP = csr_unit_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f csr_unit.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
